//--- source/layer_memory.sv
`timescale 1ns/1ps
`include "patch_cfg.svh"

module layer_memory (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     load_en,
	input  membrane_pkg::grid_t      hit,
	input  membrane_pkg::node_addr_t read_addr,
	output membrane_pkg::sample_t    read_current,
	output membrane_pkg::sample_t    read_previous,
	input  logic                     we,
	input  membrane_pkg::node_addr_t write_addr,
	input  membrane_pkg::sample_t    write_data,
	input  logic                     rotate,
	output membrane_pkg::grid_t      newest
);
	import membrane_pkg::*;

	sample_t    bank [`LAYER_COUNT][`NODE_COUNT];
	layer_sel_t ptr;                                  // points at the previous layer
	layer_sel_t prev_sel;
	layer_sel_t cur_sel;
	layer_sel_t new_sel;

	function automatic layer_sel_t next_sel(input layer_sel_t sel);
		return (sel == layer_sel_t'(`LAYER_COUNT - 1)) ? '0 : sel + layer_sel_t'(1);
	endfunction

	assign prev_sel = ptr;
	assign cur_sel  = next_sel(ptr);
	assign new_sel  = next_sel(cur_sel);

	always_ff @(posedge clock) begin
		if (!reset) begin
			ptr <= '0;
			for (int l = 0; l < `LAYER_COUNT; l++) begin
				for (int n = 0; n < `NODE_COUNT; n++) begin
					bank[l][n] <= '0;
				end
			end
		end else begin
			if (load_en) begin
				for (int n = 0; n < `NODE_COUNT; n++) begin
					bank[cur_sel][n]  <= hit.node[n];
					bank[prev_sel][n] <= '0;     // membrane starts at rest
				end
			end else if (we) begin
				bank[new_sel][write_addr] <= write_data;
			end
			if (rotate) begin
				ptr <= cur_sel;                  // new becomes current, current becomes previous
			end
		end
	end

	// reads answer within the cycle
	assign read_current  = bank[cur_sel][read_addr];
	assign read_previous = bank[prev_sel][read_addr];

	always_comb begin
		for (int n = 0; n < `NODE_COUNT; n++) begin
			newest.node[n] = bank[new_sel][n];
		end
	end

	we_rotate_apart: assert property (@(posedge clock) disable iff (!reset)
		!(we && rotate));

endmodule

//--- source/membrane_pkg.sv
`include "patch_cfg.svh"

package membrane_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;          // displacement, 17 fraction bits
	typedef logic [`SAMPLE_W-1:0] rho_t;                    // unsigned coupling fraction
	typedef logic [$clog2(`NODE_COUNT)-1:0] node_addr_t;    // row-major node index
	typedef logic [$clog2(`LAYER_COUNT)-1:0] layer_sel_t;

	// node 0 top-left, row-major
	typedef struct packed {
		sample_t [`NODE_COUNT-1:0] node;
	} grid_t;

	// left/right indexed by row, up/down by column
	typedef struct packed {
		sample_t [`PATCH_DIM-1:0] left;
		sample_t [`PATCH_DIM-1:0] right;
		sample_t [`PATCH_DIM-1:0] up;
		sample_t [`PATCH_DIM-1:0] down;
	} edge_t;

	typedef struct packed {
		sample_t current;
		sample_t previous;
		sample_t right;
		sample_t left;
		sample_t up;
		sample_t down;
	} stencil_t;

	typedef enum logic [3:0] {
		s_idle, s_center, s_right, s_left, s_up, s_down, s_compute, s_write, s_rotate
	} sweep_state_t;

	typedef enum logic [2:0] {rd_center, rd_right, rd_left, rd_up, rd_down} read_sel_t;

endpackage

//--- source/neighbor_gather.sv
`timescale 1ns/1ps
`include "patch_cfg.svh"

module neighbor_gather (
	input  logic                      clock,
	input  logic                      reset,
	input  membrane_pkg::sweep_state_t state,
	input  logic                      read_en,
	input  membrane_pkg::read_sel_t    read_sel,
	input  membrane_pkg::node_addr_t   node,
	input  logic                      at_top,
	input  logic                      at_bottom,
	input  logic                      at_left,
	input  logic                      at_right,
	input  membrane_pkg::edge_t        edges,
	input  membrane_pkg::sample_t      read_current,
	input  membrane_pkg::sample_t      read_previous,
	output membrane_pkg::node_addr_t   read_addr,
	output membrane_pkg::stencil_t     stencil
);
	import membrane_pkg::*;

	localparam int DIM_W = $clog2(`PATCH_DIM);
	localparam node_addr_t ROW_STEP = node_addr_t'(`PATCH_DIM);

	logic [DIM_W-1:0] row;
	logic [DIM_W-1:0] col;

	assign col = node[DIM_W-1:0];
	assign row = node[2*DIM_W-1:DIM_W];

	// neighbor address per phase, border phases stay on the node itself
	always_comb begin
		case (state)
			s_right: read_addr = at_right  ? node : node + node_addr_t'(1);
			s_left:  read_addr = at_left   ? node : node - node_addr_t'(1);
			s_up:    read_addr = at_top    ? node : node - ROW_STEP;
			s_down:  read_addr = at_bottom ? node : node + ROW_STEP;
			default: read_addr = node;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			stencil <= '0;
		end else if (read_en) begin
			case (read_sel)
				rd_center: begin
					stencil.current  <= read_current;   // both layers from one read
					stencil.previous <= read_previous;
				end
				rd_right: stencil.right <= at_right  ? edges.right[row] : read_current;
				rd_left:  stencil.left  <= at_left   ? edges.left[row]  : read_current;
				rd_up:    stencil.up    <= at_top    ? edges.up[col]    : read_current;
				rd_down:  stencil.down  <= at_bottom ? edges.down[col]  : read_current;
				default:  stencil <= stencil;
			endcase
		end
	end

endmodule

//--- source/node_counter.sv
`timescale 1ns/1ps
`include "patch_cfg.svh"

module node_counter (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    step,
	input  logic                    clear,
	output membrane_pkg::node_addr_t node,
	output logic                    at_top,
	output logic                    at_bottom,
	output logic                    at_left,
	output logic                    at_right,
	output logic                    last_node
);
	import membrane_pkg::*;

	localparam int DIM_W = $clog2(`PATCH_DIM);
	localparam logic [DIM_W-1:0] EDGE_IDX = DIM_W'(`PATCH_DIM - 1);

	logic [DIM_W-1:0] row;
	logic [DIM_W-1:0] col;

	always_ff @(posedge clock) begin
		if (!reset) begin
			node <= '0;
		end else if (clear) begin
			node <= '0;                          // clear wins over step
		end else if (step) begin
			node <= node + node_addr_t'(1);
		end
	end

	// row-major split of the address
	assign col = node[DIM_W-1:0];
	assign row = node[2*DIM_W-1:DIM_W];

	assign at_top    = (row == '0);
	assign at_bottom = (row == EDGE_IDX);
	assign at_left   = (col == '0);
	assign at_right  = (col == EDGE_IDX);
	assign last_node = (node == node_addr_t'(`NODE_COUNT - 1));

	// wrap back to node 0 only through clear
	step_at_last: assert property (@(posedge clock) disable iff (!reset)
		step && last_node |-> clear);

endmodule

//--- source/node_update.sv
`timescale 1ns/1ps
`include "patch_cfg.svh"

module node_update (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   compute,
	input  membrane_pkg::stencil_t stencil,
	input  membrane_pkg::rho_t     rho,
	output membrane_pkg::sample_t  result
);
	import membrane_pkg::*;

	localparam logic signed [39:0] SAT_MAX = (40'sd1 <<< (`SAMPLE_W - 1)) - 40'sd1;
	localparam logic signed [39:0] SAT_MIN = -(40'sd1 <<< (`SAMPLE_W - 1));

	logic signed [20:0] laplacian;
	logic signed [39:0] product;
	logic signed [39:0] total;
	sample_t            saturated;

	always_comb begin
		laplacian = $signed(stencil.right) + $signed(stencil.left)
			+ $signed(stencil.up) + $signed(stencil.down)
			- ($signed(stencil.current) <<< 2);
		product = laplacian * $signed({1'b0, rho});     // rho is a positive fraction
		total = (product >>> `FRAC_W) + ($signed(stencil.current) <<< 1)
			- $signed(stencil.previous);
		if (total > SAT_MAX) begin
			saturated = SAT_MAX[`SAMPLE_W-1:0];
		end else if (total < SAT_MIN) begin
			saturated = SAT_MIN[`SAMPLE_W-1:0];
		end else begin
			saturated = total[`SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			result <= '0;
		end else if (compute) begin
			result <= saturated;                     // valid during the write phase
		end
	end

endmodule

//--- source/patch_cfg.svh
`ifndef PATCH_CFG_SVH
`define PATCH_CFG_SVH

// patch geometry, nodes per side and in total
`define PATCH_DIM 4
`define NODE_COUNT 16

// signed fixed point samples
`define SAMPLE_W 18
`define FRAC_W 17

// previous, current and new layers
`define LAYER_COUNT 3

`endif

//--- source/patch_top.sv
`timescale 1ns/1ps

module patch_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                load,
	input  membrane_pkg::grid_t hit,
	input  logic                start,
	input  membrane_pkg::edge_t edges,
	input  membrane_pkg::rho_t  rho,
	output membrane_pkg::grid_t grid,
	output logic                busy,
	output logic                done
);
	import membrane_pkg::*;

	sweep_state_t state;
	read_sel_t    read_sel;
	node_addr_t   node;
	node_addr_t   read_addr;
	sample_t      read_current;
	sample_t      read_previous;
	sample_t      result;
	stencil_t     stencil;
	grid_t        newest;
	logic step, clear, read_en, mem_we, rotate, load_en, last_node;
	logic at_top, at_bottom, at_left, at_right;

	sweep_fsm u_fsm (
		.clock(clock), .reset(reset), .start(start), .load(load), .last_node(last_node),
		.state(state), .step(step), .clear(clear), .read_en(read_en), .read_sel(read_sel),
		.mem_we(mem_we), .rotate(rotate), .load_en(load_en), .busy(busy), .done(done)
	);

	node_counter u_counter (
		.clock(clock), .reset(reset), .step(step), .clear(clear), .node(node),
		.at_top(at_top), .at_bottom(at_bottom), .at_left(at_left), .at_right(at_right),
		.last_node(last_node)
	);

	// writes land on the node still held by the counter
	layer_memory u_memory (
		.clock(clock), .reset(reset), .load_en(load_en), .hit(hit), .read_addr(read_addr),
		.read_current(read_current), .read_previous(read_previous), .we(mem_we),
		.write_addr(node), .write_data(result), .rotate(rotate), .newest(newest)
	);

	neighbor_gather u_gather (
		.clock(clock), .reset(reset), .state(state), .read_en(read_en), .read_sel(read_sel),
		.node(node), .at_top(at_top), .at_bottom(at_bottom), .at_left(at_left),
		.at_right(at_right), .edges(edges), .read_current(read_current),
		.read_previous(read_previous), .read_addr(read_addr), .stencil(stencil)
	);

	node_update u_update (
		.clock(clock), .reset(reset), .compute(state == s_compute), .stencil(stencil),
		.rho(rho), .result(result)
	);

	// output grid follows the layer finished by this sweep
	always_ff @(posedge clock) begin
		if (!reset) begin
			grid <= '0;
		end else if (rotate) begin
			grid <= newest;                          // shows up with done
		end
	end

endmodule

//--- source/sweep_fsm.sv
`timescale 1ns/1ps

module sweep_fsm (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      load,
	input  logic                      last_node,
	output membrane_pkg::sweep_state_t state,
	output logic                      step,
	output logic                      clear,
	output logic                      read_en,
	output membrane_pkg::read_sel_t    read_sel,
	output logic                      mem_we,
	output logic                      rotate,
	output logic                      load_en,
	output logic                      busy,
	output logic                      done
);
	import membrane_pkg::*;

	sweep_state_t next_state;

	always_ff @(posedge clock) begin
		if (!reset) begin
			state <= s_idle;
			done  <= 1'b0;
		end else begin
			state <= next_state;
			done  <= (state == s_rotate);     // lines up with the grid register
		end
	end

	// seven phases per node, then one rotate cycle
	always_comb begin
		case (state)
			s_idle:    next_state = start ? s_center : s_idle;
			s_center:  next_state = s_right;
			s_right:   next_state = s_left;
			s_left:    next_state = s_up;
			s_up:      next_state = s_down;
			s_down:    next_state = s_compute;
			s_compute: next_state = s_write;
			s_write:   next_state = last_node ? s_rotate : s_center;
			s_rotate:  next_state = s_idle;
			default:   next_state = s_idle;
		endcase
	end

	// which stencil field the current phase fills
	always_comb begin
		case (state)
			s_right: read_sel = rd_right;
			s_left:  read_sel = rd_left;
			s_up:    read_sel = rd_up;
			s_down:  read_sel = rd_down;
			default: read_sel = rd_center;
		endcase
	end

	assign read_en = (state inside {s_center, s_right, s_left, s_up, s_down});
	assign mem_we  = (state == s_write);
	assign rotate  = (state == s_rotate);
	assign step    = (state == s_write);
	assign clear   = (state == s_idle) || (state == s_write && last_node);
	assign load_en = (state == s_idle) && load;     // hit only taken between sweeps
	assign busy    = (state != s_idle);

	done_single: assert property (@(posedge clock) disable iff (!reset)
		done |=> !done);

	// a start mid-sweep must not restart the node phases
	start_ignored: assert property (@(posedge clock) disable iff (!reset)
		start && busy && state != s_write |=> state != s_center);

endmodule

//--- tb.f
+incdir+source
source/membrane_pkg.sv
source/node_counter.sv
source/sweep_fsm.sv
source/layer_memory.sv
source/neighbor_gather.sv
source/node_update.sv
source/patch_top.sv
tb/tb_patch.sv

//--- tb/tb_patch.sv
`timescale 1ns/1ps
`include "patch_cfg.svh"

module tb_patch;
	import membrane_pkg::*;

	localparam longint SAT_HI = (longint'(1) << (`SAMPLE_W - 1)) - 1;
	localparam longint SAT_LO = -(longint'(1) << (`SAMPLE_W - 1));

	logic  clock, reset, load, start, busy, done;
	grid_t hit, grid;
	edge_t edges;
	rho_t  rho;
	grid_t m_prev, m_cur, m_new;              // reference model layers
	string cur_test;
	int    test_errors, total_errors, tests_run, tests_failed, seed_ret;

	patch_top u_dut (
		.clock(clock), .reset(reset), .load(load), .hit(hit), .start(start),
		.edges(edges), .rho(rho), .grid(grid), .busy(busy), .done(done)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic longint value_of(input sample_t s);
		return s;                                  // sign extends
	endfunction

	function automatic sample_t saturate(input longint value);
		if (value > SAT_HI) return sample_t'(SAT_HI);
		if (value < SAT_LO) return sample_t'(SAT_LO);
		return sample_t'(value);
	endfunction

	// finite-difference rule with edge substitution at the border
	function automatic grid_t compute_next_layer(input grid_t cur, input grid_t prev,
			input edge_t e, input rho_t r);
		grid_t  nxt;
		longint c, p, rt, lf, up, dn, lap;
		int     row, col;
		for (int n = 0; n < `NODE_COUNT; n++) begin
			row = n / `PATCH_DIM;
			col = n % `PATCH_DIM;
			c = value_of(cur.node[n]);
			p = value_of(prev.node[n]);
			rt = (col == `PATCH_DIM - 1) ? value_of(e.right[row]) : value_of(cur.node[n + 1]);
			lf = (col == 0) ? value_of(e.left[row]) : value_of(cur.node[n - 1]);
			up = (row == 0) ? value_of(e.up[col]) : value_of(cur.node[n - `PATCH_DIM]);
			dn = (row == `PATCH_DIM - 1) ? value_of(e.down[col])
				: value_of(cur.node[n + `PATCH_DIM]);
			lap = rt + lf + up + dn - 4 * c;
			nxt.node[n] = saturate(((lap * longint'(r)) >>> `FRAC_W) + 2 * c - p);
		end
		return nxt;
	endfunction

	function automatic grid_t random_grid();
		grid_t g;
		for (int n = 0; n < `NODE_COUNT; n++) g.node[n] = sample_t'($urandom);
		return g;
	endfunction

	function automatic edge_t random_edges();
		edge_t e;
		for (int i = 0; i < `PATCH_DIM; i++) begin
			e.left[i]  = sample_t'($urandom);
			e.right[i] = sample_t'($urandom);
			e.up[i]    = sample_t'($urandom);
			e.down[i]  = sample_t'($urandom);
		end
		return e;
	endfunction

	function automatic rho_t random_rho();
		return rho_t'($urandom % 32769);           // 0 up to 0.25
	endfunction

	task automatic check_grid(input string label, input grid_t expected, input grid_t actual);
		for (int n = 0; n < `NODE_COUNT; n++) begin
			if (actual.node[n] !== expected.node[n]) begin
				$display("** Error: %s: %s node %0d expected %0d, actual %0d", cur_test, label, n,
					expected.node[n], actual.node[n]);
				test_errors++;
			end
		end
	endtask

	task automatic check_sample(input string label, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			$display("** Error: %s: %s expected %0d, actual %0d", cur_test, label, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string label, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error: %s: %s expected %b, actual %b", cur_test, label, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) tests_failed++;
		$display("%-22s %s (%0d errors)", cur_test, (test_errors == 0) ? "ok" : "failed",
			test_errors);
	endtask

	task automatic drive_load(input grid_t h);
		@(posedge clock);
		#5;
		hit = h;
		load = 1'b1;
		@(posedge clock);
		#5;
		load = 1'b0;
		m_cur = h;
		m_prev = '0;
	endtask

	task automatic pulse_start();
		@(posedge clock);
		#5;
		start = 1'b1;
		@(posedge clock);
		#5;
		start = 1'b0;
	endtask

	task automatic wait_done(output bit ok);
		ok = 1'b0;
		for (int c = 0; c < 300 && !ok; c++) begin
			@(negedge clock);
			if (done) ok = 1'b1;
		end
		if (!ok) begin
			$display("%s: done did not arrive within 300 cycles", cur_test);
			test_errors++;
		end
	endtask

	task automatic advance_model();
		m_new = compute_next_layer(m_cur, m_prev, edges, rho);
		m_prev = m_cur;
		m_cur = m_new;
	endtask

	task automatic sweep_and_check();
		bit ok;
		pulse_start();
		wait_done(ok);
		advance_model();
		if (ok) begin
			check_grid("grid", m_new, grid);
			check_bit("busy at done", 1'b0, busy);
		end
	endtask

	task automatic zero_rho_doubling();
		grid_t h, expected;
		begin_test("zero_rho_doubling");
		h = random_grid();
		h.node[0] = sample_t'(SAT_HI);              // pushes past both limits
		h.node[1] = sample_t'(SAT_LO);
		h.node[2] = sample_t'(65536);
		h.node[3] = sample_t'(-65537);
		for (int n = 0; n < `NODE_COUNT; n++) expected.node[n] = saturate(2 * value_of(h.node[n]));
		rho = '0;
		edges = random_edges();
		drive_load(h);
		sweep_and_check();
		check_grid("doubled hit", expected, grid);
		end_test();
	endtask

	task automatic random_single_sweep();
		begin_test("random_single_sweep");
		rho = random_rho();
		edges = '0;
		drive_load(random_grid());
		sweep_and_check();
		end_test();
	endtask

	task automatic five_sweep_rotation();
		begin_test("five_sweep_rotation");
		rho = random_rho();
		edges = random_edges();
		drive_load(random_grid());
		repeat (5) sweep_and_check();
		end_test();
	endtask

	task automatic edge_driven_border();
		bit ok;
		int row, col;
		begin_test("edge_driven_border");
		rho = rho_t'(16384 + $urandom % 16385);
		edges = random_edges();
		drive_load('0);
		pulse_start();
		wait_done(ok);
		advance_model();
		for (int n = 0; n < `NODE_COUNT && ok; n++) begin
			row = n / `PATCH_DIM;
			col = n % `PATCH_DIM;
			if (row > 0 && row < `PATCH_DIM - 1 && col > 0 && col < `PATCH_DIM - 1)
				check_sample($sformatf("interior node %0d", n), '0, grid.node[n]);
			else
				check_sample($sformatf("border node %0d", n), m_new.node[n], grid.node[n]);
		end
		end_test();
	endtask

	task automatic start_while_busy();
		int dones;
		begin_test("start_while_busy");
		dones = 0;
		rho = random_rho();
		edges = '0;
		drive_load(random_grid());
		pulse_start();
		for (int c = 1; c <= 150; c++) begin
			@(posedge clock);
			#5;
			start = (c == 3 || c == 40 || c == 90);    // extra starts mid sweep
			@(negedge clock);
			if (c == 50) check_bit("busy mid sweep", 1'b1, busy);
			if (done) begin
				dones++;
				if (dones == 1) begin
					advance_model();
					check_bit("busy at done", 1'b0, busy);
					check_grid("grid", m_new, grid);
				end
			end
		end
		if (dones != 1) begin
			$display("** Error: %s: done pulses expected 1, actual %0d", cur_test, dones);
			test_errors++;
		end
		end_test();
	endtask

	task automatic reset_mid_sweep();
		begin_test("reset_mid_sweep");
		rho = random_rho();
		edges = random_edges();
		drive_load(random_grid());
		pulse_start();
		repeat (40) @(posedge clock);
		#5;
		reset = 1'b0;
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b1;
		m_prev = '0;
		m_cur = '0;
		@(negedge clock);
		check_bit("busy after reset", 1'b0, busy);
		check_bit("done after reset", 1'b0, done);
		check_grid("grid after reset", '0, grid);
		drive_load(random_grid());
		sweep_and_check();
		end_test();
	endtask

	initial begin
		seed_ret = $urandom(32'h223b);
		reset = 1'b0;
		load = 1'b0;
		start = 1'b0;
		hit = '0;
		edges = '0;
		rho = '0;
		m_prev = '0;
		m_cur = '0;
		m_new = '0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b1;
		zero_rho_doubling();
		random_single_sweep();
		five_sweep_rotation();
		edge_driven_border();
		start_while_busy();
		reset_mid_sweep();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
